/* design/panel_macros.svh */
/*
 * panel tester parameters
 * bus widths, channel counts and gate timing constants
 */
`ifndef PANEL_MACROS_SVH
`define PANEL_MACROS_SVH

// --------------------------------------------------
// host bus
// --------------------------------------------------
`define PANEL_DATA_W        32      // apb data width
`define PANEL_ADDR_W        8       // apb address width

// --------------------------------------------------
// power rails and gate timing
// --------------------------------------------------
`define PANEL_RAILS         6       // p14v n14v gvddp gvddn vgh vgl
`define PANEL_POWER_STEP    16      // cycles between rail enables
`define PANEL_LINE_CYCLES   32      // clocks per gate line
`define PANEL_FRAME_LINES   16      // lines per frame
`define PANEL_CKV_PHASES    4       // vertical clock phases

// --------------------------------------------------
// level dacs and analog switches
// --------------------------------------------------
`define PANEL_DAC_NUM       4
`define PANEL_DAC_W         8
`define PANEL_MUX_CH        7       // stv, ckv x4, dir, grst

`endif

/* design/panel_regs_pkg.sv */
/*
 * panel tester register map
 * apb addresses, the two decodes of a write word and the status layout
 */
`include "panel_macros.svh"

package panel_regs_pkg;

    localparam logic [`PANEL_ADDR_W-1:0] CTRL_ADDR   = 'h00;
    localparam logic [`PANEL_ADDR_W-1:0] DAC_ADDR    = 'h04;
    localparam logic [`PANEL_ADDR_W-1:0] STATUS_ADDR = 'h08;

    // control view of a write word
    typedef struct packed {
        logic [`PANEL_DATA_W-4:0] rsvd;
        logic                     right_off;  // blank right-side ckv
        logic                     scan_dir;   // 1 = top to bottom
        logic                     enable;     // start power-up
    } ctrl_word_t;

    // dac view of a write word
    typedef struct packed {
        logic [`PANEL_DATA_W-13:0] rsvd;
        logic [1:0]                channel;   // which dac
        logic [1:0]                reg_addr;  // dac internal register
        logic [`PANEL_DAC_W-1:0]   level;
    } dac_word_t;

    typedef union packed {
        ctrl_word_t ctrl;
        dac_word_t  dac;
    } apb_word_u;

    typedef struct packed {
        logic [`PANEL_DATA_W-3:0] rsvd;
        logic                     dac_busy;
        logic                     power_good;
    } status_t;

endpackage

/* design/panel_timing_pkg.sv */
/*
 * gate timing switch codes
 * code type and channel slots of the registered timing outputs
 */
package panel_timing_pkg;

    // {first signal, second signal} of a pair
    typedef logic [1:0] mux_code_t;

    // --------------------------------------------------
    // channel slots
    // --------------------------------------------------
    localparam int CH_STV  = 0;
    localparam int CH_CKV0 = 1;   // ckv phase k sits at CH_CKV0 + k
    localparam int CH_CKV1 = 2;
    localparam int CH_CKV2 = 3;
    localparam int CH_CKV3 = 4;
    localparam int CH_DIR  = 5;   // u2d / d2u
    localparam int CH_GRST = 6;

endpackage

/* design/panel_ctrl.sv */
/*
 * panel control
 * apb register file, dac command decode and the supply rail sequencer
 */
`timescale 1ns/1ps
`include "panel_macros.svh"

module panel_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`PANEL_ADDR_W-1:0] paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`PANEL_DATA_W-1:0] pwdata,
    output logic [`PANEL_DATA_W-1:0] prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     dac_busy,
    output logic                     dac_req,
    output logic [1:0]               dac_channel,
    output logic [1:0]               dac_addr,
    output logic [`PANEL_DAC_W-1:0]  dac_level,
    output logic [`PANEL_RAILS-1:0]  rail_en,
    output logic                     power_good,
    output logic                     scan_dir,
    output logic                     right_off
);

    localparam int STEP_W = $clog2(`PANEL_POWER_STEP);
    localparam int IDX_W  = $clog2(`PANEL_RAILS + 1);

    panel_regs_pkg::apb_word_u  wr_word;
    panel_regs_pkg::ctrl_word_t ctrl_q;
    panel_regs_pkg::status_t    status;
    logic                       access;
    logic                       dac_sel;
    logic                       ctrl_wr;
    logic                       en_next;
    logic [STEP_W-1:0]          step_cnt;
    logic [IDX_W-1:0]           rail_idx;

    // --------------------------------------------------
    // apb decode
    // --------------------------------------------------
    assign wr_word = pwdata;
    assign access  = psel && penable;
    assign dac_sel = (paddr == panel_regs_pkg::DAC_ADDR);
    assign ctrl_wr = access && pwrite && (paddr == panel_regs_pkg::CTRL_ADDR);
    assign pready  = !(psel && pwrite && dac_sel && dac_busy);   // wait on busy loader
    assign pslverr = access && !(paddr inside {panel_regs_pkg::CTRL_ADDR,
                                               panel_regs_pkg::DAC_ADDR,
                                               panel_regs_pkg::STATUS_ADDR});

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q <= '0;
        end else if (ctrl_wr) begin
            ctrl_q <= wr_word.ctrl;   // whole word kept for read-back
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dac_req <= 1'b0;
        end else begin
            dac_req <= access && pwrite && dac_sel && !dac_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (access && pwrite && dac_sel && !dac_busy) begin
            dac_channel <= wr_word.dac.channel;
            dac_addr    <= wr_word.dac.reg_addr;
            dac_level   <= wr_word.dac.level;
        end
    end

    always_comb begin
        status            = '0;
        status.power_good = power_good;
        status.dac_busy   = dac_busy;
        case (paddr)
            panel_regs_pkg::CTRL_ADDR:   prdata = ctrl_q;
            panel_regs_pkg::STATUS_ADDR: prdata = status;
            default:                     prdata = '0;
        endcase
    end

    // --------------------------------------------------
    // rail sequencer
    // --------------------------------------------------
    // the new enable value takes effect at the write edge itself
    assign en_next = ctrl_wr ? wr_word.ctrl.enable : ctrl_q.enable;

    always_ff @(posedge clk) begin
        if (reset || !en_next) begin
            rail_en  <= '0;
            rail_idx <= '0;
            step_cnt <= '0;
        end else if (rail_idx < IDX_W'(`PANEL_RAILS)) begin
            if (rail_idx == '0 || step_cnt == STEP_W'(`PANEL_POWER_STEP - 1)) begin
                rail_en[rail_idx] <= 1'b1;
                rail_idx          <= rail_idx + 1'b1;
                step_cnt          <= '0;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    assign power_good = rail_en[`PANEL_RAILS-1];   // last rail up
    assign scan_dir   = ctrl_q.scan_dir;
    assign right_off  = ctrl_q.right_off;

    a_rails_in_order : assert property (@(posedge clk) disable iff (reset)
        (rail_en & (rail_en + 1'b1)) == '0);

    a_req_when_idle : assert property (@(posedge clk) disable iff (reset)
        dac_req |-> !dac_busy);

endmodule

/* design/gate_timing_gen.sv */
/*
 * gate timing generator
 * line and frame counters, four-phase ckv and registered switch codes
 */
`timescale 1ns/1ps
`include "panel_macros.svh"

module gate_timing_gen (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      timing_run,
    input  logic                      scan_dir,
    input  logic                      right_off,
    output panel_timing_pkg::mux_code_t mux_code [`PANEL_MUX_CH]
);

    localparam int CYC_W  = $clog2(`PANEL_LINE_CYCLES);
    localparam int LINE_W = $clog2(`PANEL_FRAME_LINES);
    localparam int PH_W   = $clog2(`PANEL_CKV_PHASES);

    logic [CYC_W-1:0]             cyc_cnt;
    logic [LINE_W-1:0]            line_cnt;
    logic [PH_W-1:0]              phase;
    logic                         stv;
    logic [`PANEL_CKV_PHASES-1:0] ckv_l;
    logic [`PANEL_CKV_PHASES-1:0] ckv_r;
    logic                         u2d;
    logic                         d2u;
    logic                         grst;

    // --------------------------------------------------
    // line and frame counters
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || !timing_run) begin
            cyc_cnt  <= '0;
            line_cnt <= '0;
        end else if (cyc_cnt == CYC_W'(`PANEL_LINE_CYCLES - 1)) begin
            cyc_cnt <= '0;
            if (line_cnt == LINE_W'(`PANEL_FRAME_LINES - 1)) begin
                line_cnt <= '0;   // next frame
            end else begin
                line_cnt <= line_cnt + 1'b1;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    assign phase = line_cnt[PH_W-1:0];
    assign stv   = timing_run && (line_cnt == '0);
    assign u2d   = scan_dir;
    assign d2u   = !scan_dir;
    assign grst  = !timing_run;   // panel held in reset while idle

    for (genvar k = 0; k < `PANEL_CKV_PHASES; k++) begin : g_ckv
        // bottom-to-top runs the phases in reverse
        assign ckv_l[k] = timing_run &&
                          (phase == (scan_dir ? PH_W'(k) : PH_W'(`PANEL_CKV_PHASES - 1 - k)));
        assign ckv_r[k] = ckv_l[k] && !right_off;
    end

    // --------------------------------------------------
    // switch codes, one register stage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        mux_code[panel_timing_pkg::CH_STV] <= {stv, stv};
        for (int k = 0; k < `PANEL_CKV_PHASES; k++) begin
            mux_code[panel_timing_pkg::CH_CKV0 + k] <= {ckv_l[k], ckv_r[k]};
        end
        mux_code[panel_timing_pkg::CH_DIR]  <= {u2d, d2u};
        mux_code[panel_timing_pkg::CH_GRST] <= {grst, grst};
    end

    a_one_ckv_phase : assert property (@(posedge clk) disable iff (reset)
        timing_run |-> $onehot(ckv_l));

endmodule

/* design/dac_loader.sv */
/*
 * dac loader
 * turns one dac request into address, data and write-strobe cycles
 */
`timescale 1ns/1ps
`include "panel_macros.svh"

module dac_loader (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req,
    input  logic [1:0]              channel,
    input  logic [1:0]              addr,
    input  logic [`PANEL_DAC_W-1:0] level,
    output logic                    busy,
    output logic [`PANEL_DAC_NUM-1:0] da_wr,
    output logic [1:0]              da_a   [`PANEL_DAC_NUM],
    output logic [`PANEL_DAC_W-1:0] da_din [`PANEL_DAC_NUM]
);

    typedef enum logic [1:0] {IDLE, SETUP, STROBE, HOLD} state_t;

    state_t     state;
    logic [1:0] ch_q;   // channel of the write in flight

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (req) state <= SETUP;
                SETUP:   state <= STROBE;
                STROBE:  state <= HOLD;
                default: state <= IDLE;
            endcase
        end
    end

    // other channels keep their last address and level
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            ch_q            <= channel;
            da_a[channel]   <= addr;
            da_din[channel] <= level;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            da_wr <= '0;
        end else begin
            da_wr <= '0;
            if (state == SETUP) begin
                da_wr[ch_q] <= 1'b1;   // high during the middle cycle
            end
        end
    end

    assign busy = (state != IDLE);

    a_single_strobe : assert property (@(posedge clk) disable iff (reset)
        $onehot0(da_wr));

endmodule

/* design/panel_tester_top.sv */
/*
 * panel tester top
 * apb control, gate timing and dac loading for a gate-driver test board
 */
`timescale 1ns/1ps
`include "panel_macros.svh"

module panel_tester_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`PANEL_ADDR_W-1:0]    paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`PANEL_DATA_W-1:0]    pwdata,
    output logic [`PANEL_DATA_W-1:0]    prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        en_p14v,
    output logic                        en_n14v,
    output logic                        en_gvddp,
    output logic                        en_gvddn,
    output logic                        en_vgh,
    output logic                        en_vgl,
    output panel_timing_pkg::mux_code_t mux_code [`PANEL_MUX_CH],
    output logic [`PANEL_DAC_NUM-1:0]   da_wr,
    output logic [1:0]                  da_a   [`PANEL_DAC_NUM],
    output logic [`PANEL_DAC_W-1:0]     da_din [`PANEL_DAC_NUM]
);

    logic                    dac_req;
    logic                    dac_busy;
    logic [1:0]              dac_channel;
    logic [1:0]              dac_addr;
    logic [`PANEL_DAC_W-1:0] dac_level;
    logic [`PANEL_RAILS-1:0] rail_en;
    logic                    power_good;
    logic                    scan_dir;
    logic                    right_off;

    // rails in power-up order
    assign en_p14v  = rail_en[0];
    assign en_n14v  = rail_en[1];
    assign en_gvddp = rail_en[2];
    assign en_gvddn = rail_en[3];
    assign en_vgh   = rail_en[4];
    assign en_vgl   = rail_en[5];

    panel_ctrl u_panel_ctrl (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .dac_busy(dac_busy), .dac_req(dac_req), .dac_channel(dac_channel),
        .dac_addr(dac_addr), .dac_level(dac_level),
        .rail_en(rail_en), .power_good(power_good),
        .scan_dir(scan_dir), .right_off(right_off)
    );

    gate_timing_gen u_gate_timing_gen (
        .clk(clk), .reset(reset),
        .timing_run(power_good),   // timing starts once all rails are up
        .scan_dir(scan_dir), .right_off(right_off),
        .mux_code(mux_code)
    );

    dac_loader u_dac_loader (
        .clk(clk), .reset(reset),
        .req(dac_req), .channel(dac_channel), .addr(dac_addr), .level(dac_level),
        .busy(dac_busy),
        .da_wr(da_wr), .da_a(da_a), .da_din(da_din)
    );

endmodule

/* test/tb_panel_tester.sv */
/*
 * panel tester testbench
 * apb driver, dac strobe monitor and a reference model of the gate switch codes
 */
`timescale 1ns/1ps
`include "panel_macros.svh"

module tb_panel_tester;

    localparam int CLK_PERIOD   = 10;
    localparam int FRAME_CYCLES = `PANEL_LINE_CYCLES * `PANEL_FRAME_LINES;
    localparam int DAC_WRITES   = 40;
    localparam int WATCHDOG_CYCLES =
        2 * (3 * FRAME_CYCLES + `PANEL_RAILS * `PANEL_POWER_STEP + DAC_WRITES * 6);

    logic                        clk;
    logic                        reset;
    logic [`PANEL_ADDR_W-1:0]    paddr;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`PANEL_DATA_W-1:0]    pwdata;
    logic [`PANEL_DATA_W-1:0]    prdata;
    logic                        pready;
    logic                        pslverr;
    logic                        en_p14v;
    logic                        en_n14v;
    logic                        en_gvddp;
    logic                        en_gvddn;
    logic                        en_vgh;
    logic                        en_vgl;
    panel_timing_pkg::mux_code_t mux_code [`PANEL_MUX_CH];
    logic [`PANEL_DAC_NUM-1:0]   da_wr;
    logic [1:0]                  da_a   [`PANEL_DAC_NUM];
    logic [`PANEL_DAC_W-1:0]     da_din [`PANEL_DAC_NUM];

    logic [31:0] rng_state;
    logic [11:0] dac_expect [$];    // {channel, reg addr, level}
    logic        check_on;          // code compare enabled
    logic        synced;            // locked to a frame start
    logic        exp_dir;
    logic        exp_roff;
    logic [1:0]  prev_stv;
    int          line_idx;
    int          cyc_idx;
    int          n_checked;

    panel_tester_top u_panel_tester_top (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .en_p14v(en_p14v), .en_n14v(en_n14v), .en_gvddp(en_gvddp),
        .en_gvddn(en_gvddn), .en_vgh(en_vgh), .en_vgl(en_vgl),
        .mux_code(mux_code),
        .da_wr(da_wr), .da_a(da_a), .da_din(da_din)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // seven codes of one running line, code c in bits 2c+1:2c
    function automatic logic [2*`PANEL_MUX_CH-1:0] expected_codes(input int line,
                                                                  input logic dir,
                                                                  input logic roff);
        logic [2*`PANEL_MUX_CH-1:0] codes;
        logic                       ph;
        codes = '0;
        codes[2*panel_timing_pkg::CH_STV +: 2] = (line == 0) ? 2'b11 : 2'b00;
        for (int k = 0; k < `PANEL_CKV_PHASES; k++) begin
            if (dir) begin
                ph = (line % `PANEL_CKV_PHASES) == k;
            end else begin
                ph = (line % `PANEL_CKV_PHASES) == (`PANEL_CKV_PHASES - 1 - k);
            end
            codes[2*(panel_timing_pkg::CH_CKV0 + k) +: 2] = {ph, ph && !roff};
        end
        codes[2*panel_timing_pkg::CH_DIR +: 2]  = {dir, !dir};
        codes[2*panel_timing_pkg::CH_GRST +: 2] = 2'b00;   // out of reset while running
        return codes;
    endfunction

    function automatic logic [`PANEL_RAILS-1:0] rails_now();
        return {en_vgl, en_vgh, en_gvddn, en_gvddp, en_n14v, en_p14v};
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        $display("Regression failed");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic apb_write(input logic [`PANEL_ADDR_W-1:0] addr, input logic [31:0] data,
                             output int waits);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        waits = 0;
        while (!pready) begin   // loader back-pressure
            @(negedge clk);
            #1;
            waits++;
        end
        @(posedge clk);
    endtask

    task automatic apb_read(input logic [`PANEL_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
        end
        data = prdata;
        err  = pslverr;
        @(posedge clk);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // --------------------------------------------------
    // monitors
    // --------------------------------------------------
    always @(negedge clk) begin : compare_codes
        logic [2*`PANEL_MUX_CH-1:0] exp_codes;
        if (check_on && !synced && mux_code[panel_timing_pkg::CH_STV] === 2'b11 &&
            prev_stv === 2'b00) begin
            synced   = 1'b1;   // first cycle of line 0
            line_idx = 0;
            cyc_idx  = 0;
        end
        if (!check_on) begin
            synced = 1'b0;
        end else if (synced) begin
            exp_codes = expected_codes(line_idx, exp_dir, exp_roff);
            for (int c = 0; c < `PANEL_MUX_CH; c++) begin
                assert (mux_code[c] === exp_codes[2*c +: 2])
                    else flag_mismatch($sformatf("mux_code[%0d]", c), exp_codes[2*c +: 2],
                                       mux_code[c]);
            end
            n_checked++;
            cyc_idx++;
            if (cyc_idx == `PANEL_LINE_CYCLES) begin
                cyc_idx  = 0;
                line_idx = (line_idx + 1) % `PANEL_FRAME_LINES;
            end
        end
        prev_stv = mux_code[panel_timing_pkg::CH_STV];
    end

    always @(negedge clk) begin : check_dac_strobe
        logic [11:0]               exp_wr;
        logic [`PANEL_DAC_NUM-1:0] exp_strobe;
        if (!reset && da_wr != '0) begin
            if (dac_expect.size() == 0) begin
                abort_run("DAC write strobe seen with no write pending");
            end else begin
                exp_wr             = dac_expect.pop_front();
                exp_strobe         = '0;
                exp_strobe[exp_wr[11:10]] = 1'b1;
                assert (da_wr == exp_strobe) else flag_mismatch("da_wr", exp_strobe, da_wr);
                assert (da_a[exp_wr[11:10]] == exp_wr[9:8])
                    else flag_mismatch("da_a", exp_wr[9:8], da_a[exp_wr[11:10]]);
                assert (da_din[exp_wr[11:10]] == exp_wr[7:0])
                    else flag_mismatch("da_din", exp_wr[7:0], da_din[exp_wr[11:10]]);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Timeout: the tests did not finish in the allowed time");
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin : run_tests
        logic [`PANEL_RAILS-1:0] rails;
        logic [`PANEL_RAILS-1:0] exp_rails;
        logic [31:0]             rdata;
        logic                    rerr;
        logic [11:0]             entry;
        int                      waits;
        int                      gap;
        clk       = 1'b0;
        reset     = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        rng_state = 32'h3aaf54e1;
        check_on  = 1'b0;
        synced    = 1'b0;
        exp_dir   = 1'b1;
        exp_roff  = 1'b0;
        n_checked = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // register access
        apb_write(panel_regs_pkg::CTRL_ADDR, 32'ha5a5_a5a6, waits);
        apb_read(panel_regs_pkg::CTRL_ADDR, rdata, rerr);
        assert (rdata == 32'ha5a5_a5a6) else flag_mismatch("prdata", 32'ha5a5_a5a6, rdata);
        assert (rerr == 1'b0) else flag_mismatch("pslverr", 0, rerr);
        apb_read(panel_regs_pkg::STATUS_ADDR, rdata, rerr);
        assert (rdata[0] == 1'b0) else flag_mismatch("status.power_good", 0, rdata[0]);
        apb_read(8'h0c, rdata, rerr);
        assert (rerr == 1'b1) else flag_mismatch("pslverr", 1, rerr);

        // dac writes, back to back
        for (int i = 0; i < DAC_WRITES; i++) begin
            rng_state = next_random(rng_state);
            entry     = rng_state[11:0];
            dac_expect.push_back(entry);
            apb_write(panel_regs_pkg::DAC_ADDR, {20'h0, entry}, waits);
            if (i > 0) begin
                assert (waits > 0)
                    else abort_run("pready did not hold off a DAC write to a busy loader");
            end
            if (i == 0) begin
                // loader has taken the request by the read access
                apb_read(panel_regs_pkg::STATUS_ADDR, rdata, rerr);
                assert (rdata[1] == 1'b1) else flag_mismatch("status.dac_busy", 1, rdata[1]);
            end
        end
        bus_idle();
        repeat (5) @(negedge clk);
        assert (dac_expect.size() == 0) else abort_run("a DAC write ended without a strobe");

        // power-up, then forward scan
        @(posedge clk);
        n_checked = 0;
        check_on  = 1'b1;
        apb_write(panel_regs_pkg::CTRL_ADDR, 32'h3, waits);
        bus_idle();
        rails = rails_now();
        assert (rails == 1) else flag_mismatch("rail_en", 1, rails);
        for (int r = 1; r < `PANEL_RAILS; r++) begin
            gap = 0;
            while (rails_now() == rails && gap <= `PANEL_POWER_STEP) begin
                @(negedge clk);
                gap++;
            end
            rails     = rails_now();
            exp_rails = (1 << (r + 1)) - 1;
            assert (gap == `PANEL_POWER_STEP)
                else flag_mismatch("rail step cycles", `PANEL_POWER_STEP, gap);
            assert (rails == exp_rails) else flag_mismatch("rail_en", exp_rails, rails);
        end
        apb_read(panel_regs_pkg::STATUS_ADDR, rdata, rerr);
        bus_idle();
        assert (rdata[0] == 1'b1) else flag_mismatch("status.power_good", 1, rdata[0]);
        wait (n_checked >= 2 * FRAME_CYCLES);
        @(posedge clk);
        check_on = 1'b0;

        // reverse scan, right side blanked
        apb_write(panel_regs_pkg::CTRL_ADDR, 32'h5, waits);
        bus_idle();
        exp_dir  = 1'b0;
        exp_roff = 1'b1;
        @(posedge clk);
        n_checked = 0;
        check_on  = 1'b1;
        wait (n_checked >= FRAME_CYCLES);
        @(posedge clk);
        check_on = 1'b0;

        // shutdown
        apb_write(panel_regs_pkg::CTRL_ADDR, 32'h0, waits);
        bus_idle();
        rails = rails_now();
        assert (rails == '0) else flag_mismatch("rail_en", 0, rails);
        @(negedge clk);
        assert (mux_code[panel_timing_pkg::CH_GRST] == 2'b11)
            else flag_mismatch("grst code", 2'b11, mux_code[panel_timing_pkg::CH_GRST]);
        assert (mux_code[panel_timing_pkg::CH_STV] == 2'b00)
            else flag_mismatch("stv code", 2'b00, mux_code[panel_timing_pkg::CH_STV]);
        for (int k = 0; k < `PANEL_CKV_PHASES; k++) begin
            assert (mux_code[panel_timing_pkg::CH_CKV0 + k] == 2'b00)
                else flag_mismatch($sformatf("ckv%0d code", k), 2'b00,
                                   mux_code[panel_timing_pkg::CH_CKV0 + k]);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+design
design/panel_regs_pkg.sv
design/panel_timing_pkg.sv
design/panel_ctrl.sv
design/gate_timing_gen.sv
design/dac_loader.sv
design/panel_tester_top.sv
test/tb_panel_tester.sv

/* Bender.yml */
package:
  name: panel_tester

export_include_dirs:
  - design

sources:
  - files:
      - design/panel_regs_pkg.sv
      - design/panel_timing_pkg.sv
      - design/panel_ctrl.sv
      - design/gate_timing_gen.sv
      - design/dac_loader.sv
      - design/panel_tester_top.sv
  - target: test
    files:
      - test/tb_panel_tester.sv
